// File: rtl/cpu_aon_defs.svh
//////////////////////////////////////////////////
// CPU always-on glue constants
// Interrupt and unit counts, bit positions,
// synchronizer depth and activity hold-off length
//////////////////////////////////////////////////

`ifndef CPU_AON_DEFS_SVH
`define CPU_AON_DEFS_SVH

// Interrupt lines and their positions in an interrupt vector
`define CPU_IRQ_NUM      4
`define CPU_IRQ_DBG      0
`define CPU_IRQ_EXT      1
`define CPU_IRQ_SFT      2
`define CPU_IRQ_TMR      3

// Clock-gated units and their positions in a unit vector
`define CPU_UNIT_NUM     4
`define CPU_UNIT_IFU     0
`define CPU_UNIT_EXU     1
`define CPU_UNIT_LSU     2
`define CPU_UNIT_BIU     3

// Synchronizer and hold-off sizing
`define CPU_SYNC_STAGES  2
`define CPU_HOLD_CYCLES  4
`define CPU_HOLD_W       3

`endif

// File: rtl/cpu_aon_pkg.sv
//////////////////////////////////////////////////
// CPU always-on glue types
// Vector types for interrupts, units and hold-off
// counters, plus the power manager states
//////////////////////////////////////////////////

`include "cpu_aon_defs.svh"

package cpu_aon_pkg;

  // One bit per interrupt line, indexed by CPU_IRQ_*
  typedef logic [`CPU_IRQ_NUM-1:0] irq_vec_t;

  // One bit per gated unit, indexed by CPU_UNIT_*
  typedef logic [`CPU_UNIT_NUM-1:0] unit_vec_t;

  // Hold-off counter value
  typedef logic [`CPU_HOLD_W-1:0] hold_cnt_t;

  // Power manager states
  typedef enum logic {
    PM_RUN   = 1'b0,
    PM_SLEEP = 1'b1
  } pm_state_t;

endpackage

// File: rtl/cpu_irq_sync.sv
//////////////////////////////////////////////////
// Interrupt synchronizer
// Brings the asynchronous debug, external,
// software and timer interrupt levels into clk
//////////////////////////////////////////////////

`timescale 1ns/1ps

`include "cpu_aon_defs.svh"

module cpu_irq_sync (
  input  logic                  clk,
  input  logic                  rst_n,
  input  cpu_aon_pkg::irq_vec_t irq_a,
  output cpu_aon_pkg::irq_vec_t irq_r
);

  //////////////////////////////////////////////////
  // Per-line synchronizer chains
  //////////////////////////////////////////////////

  genvar i;

  generate
    for (i = 0; i < `CPU_IRQ_NUM; i++) begin : g_line
      // Bit 0 catches the async level, the last bit is safe to use
      logic [`CPU_SYNC_STAGES-1:0] sync_q;

      always_ff @(posedge clk) begin
        if (!rst_n) begin
          sync_q <= '0;
        end else begin
          sync_q <= {sync_q[`CPU_SYNC_STAGES-2:0], irq_a[i]};
        end
      end

      assign irq_r[i] = sync_q[`CPU_SYNC_STAGES-1];
    end
  endgenerate

endmodule

// File: rtl/cpu_activity_mon.sv
//////////////////////////////////////////////////
// Unit activity monitor
// Stretches the per-unit activity flags with a
// hold-off counter so clock gates stay steady
//////////////////////////////////////////////////

`timescale 1ns/1ps

`include "cpu_aon_defs.svh"

module cpu_activity_mon (
  input  logic                   clk,
  input  logic                   rst_n,
  input  cpu_aon_pkg::unit_vec_t unit_active,
  output cpu_aon_pkg::unit_vec_t unit_busy
);

  //////////////////////////////////////////////////
  // Hold-off counters, one per unit
  //////////////////////////////////////////////////

  genvar i;

  generate
    for (i = 0; i < `CPU_UNIT_NUM; i++) begin : g_unit
      cpu_aon_pkg::hold_cnt_t cnt_q;
      cpu_aon_pkg::hold_cnt_t cnt_d;

      // Reload on every active sample, else drain towards zero
      always_comb begin
        if (unit_active[i]) begin
          cnt_d = cpu_aon_pkg::hold_cnt_t'(`CPU_HOLD_CYCLES);
        end else if (cnt_q != '0) begin
          cnt_d = cnt_q - cpu_aon_pkg::hold_cnt_t'(1);
        end else begin
          cnt_d = cnt_q;
        end
      end

      always_ff @(posedge clk) begin
        if (!rst_n) begin
          cnt_q <= '0;
        end else begin
          cnt_q <= cnt_d;
        end
      end

      // Busy while any hold-off time is left, so the clock keeps
      // running through short idle gaps
      assign unit_busy[i] = (cnt_q != '0);
    end
  endgenerate

endmodule

// File: rtl/cpu_clk_pm.sv
//////////////////////////////////////////////////
// Power manager
// Tracks WFI sleep, wakes on an enabled interrupt
// and forms the final per-unit clock enables
//////////////////////////////////////////////////

`timescale 1ns/1ps

`include "cpu_aon_defs.svh"

module cpu_clk_pm (
  input  logic                   clk,
  input  logic                   rst_n,
  input  cpu_aon_pkg::irq_vec_t  irq_r,
  input  cpu_aon_pkg::irq_vec_t  irq_en,
  input  cpu_aon_pkg::unit_vec_t unit_busy,
  input  logic                   core_cgstop,
  input  logic                   wfi_req,
  output cpu_aon_pkg::unit_vec_t clk_en,
  output logic                   core_wfi
);

  cpu_aon_pkg::pm_state_t state_q;
  cpu_aon_pkg::pm_state_t state_d;
  logic                   wake;
  logic                   run;

  // Any synchronized interrupt that software left unmasked
  assign wake = |(irq_r & irq_en);

  //////////////////////////////////////////////////
  // Sleep/run FSM
  //////////////////////////////////////////////////

  always_comb begin
    state_d = state_q;
    unique case (state_q)
      cpu_aon_pkg::PM_RUN: begin
        // A pending wake swallows the request, no retry
        if (wfi_req && !wake) begin
          state_d = cpu_aon_pkg::PM_SLEEP;
        end
      end
      cpu_aon_pkg::PM_SLEEP: begin
        if (wake) begin
          state_d = cpu_aon_pkg::PM_RUN;
        end
      end
      default: begin
        state_d = cpu_aon_pkg::PM_RUN;
      end
    endcase
  end

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      state_q <= cpu_aon_pkg::PM_RUN;
    end else begin
      state_q <= state_d;
    end
  end

  //////////////////////////////////////////////////
  // Outputs
  //////////////////////////////////////////////////

  assign run      = (state_q == cpu_aon_pkg::PM_RUN);
  assign core_wfi = (state_q == cpu_aon_pkg::PM_SLEEP);

  // cgstop overrides both sleep and the per-unit hold-off
  assign clk_en = {`CPU_UNIT_NUM{core_cgstop}}
                | ({`CPU_UNIT_NUM{run}} & unit_busy);

endmodule

// File: rtl/cpu_aon_top.sv
//////////////////////////////////////////////////
// CPU always-on glue top level
// Interrupt sync and activity monitor side by
// side, feeding the power manager
//////////////////////////////////////////////////

`timescale 1ns/1ps

module cpu_aon_top (
  input  logic                   clk,
  input  logic                   rst_n,
  input  cpu_aon_pkg::irq_vec_t  irq_a,
  input  cpu_aon_pkg::irq_vec_t  irq_en,
  input  cpu_aon_pkg::unit_vec_t unit_active,
  input  logic                   core_cgstop,
  input  logic                   wfi_req,
  output cpu_aon_pkg::irq_vec_t  irq_r,
  output cpu_aon_pkg::unit_vec_t clk_en,
  output logic                   core_wfi
);

  cpu_aon_pkg::unit_vec_t unit_busy;

  // Interrupts into the clk domain
  cpu_irq_sync u_cpu_irq_sync (
    .clk   (clk),
    .rst_n (rst_n),
    .irq_a (irq_a),
    .irq_r (irq_r)
  );

  // Activity flags to busy with hold-off
  cpu_activity_mon u_cpu_activity_mon (
    .clk         (clk),
    .rst_n       (rst_n),
    .unit_active (unit_active),
    .unit_busy   (unit_busy)
  );

  cpu_clk_pm u_cpu_clk_pm (
    .clk         (clk),
    .rst_n       (rst_n),
    .irq_r       (irq_r),
    .irq_en      (irq_en),
    .unit_busy   (unit_busy),
    .core_cgstop (core_cgstop),
    .wfi_req     (wfi_req),
    .clk_en      (clk_en),
    .core_wfi    (core_wfi)
  );

endmodule

// File: dv/cpu_aon_assertions.sv
//////////////////////////////////////////////////
// Power manager assertions
// Sleep state, gated enables and reset value
//////////////////////////////////////////////////

`timescale 1ns/1ps

module cpu_aon_assertions (
  input logic                   clk,
  input logic                   rst_n,
  input cpu_aon_pkg::pm_state_t state_q,
  input cpu_aon_pkg::irq_vec_t  irq_r,
  input cpu_aon_pkg::irq_vec_t  irq_en,
  input logic                   wfi_req,
  input cpu_aon_pkg::unit_vec_t clk_en,
  input logic                   core_cgstop,
  input logic                   core_wfi
);

  // Read by the testbench at the end of the run
  int unsigned fail_cnt = 0;

  // Sleep is entered only on a request and left only on an enabled interrupt
  a_wfi_state: assert property (@(posedge clk) disable iff (!rst_n)
    (core_wfi != $past(core_wfi)) |->
      (core_wfi ? $past(wfi_req) : $past(|(irq_r & irq_en))))
  else begin
    fail_cnt++;
    $error("core_wfi changed without a sleep request or an enabled interrupt");
  end

  // No unit clock while asleep unless cgstop forces it
  a_sleep_gated: assert property (@(posedge clk) disable iff (!rst_n)
    (state_q == cpu_aon_pkg::PM_SLEEP && !core_cgstop) |-> (clk_en == '0))
  else begin
    fail_cnt++;
    $error("clk_en active while asleep with core_cgstop low");
  end

  a_reset_wfi: assert property (@(posedge clk) !rst_n |=> !core_wfi)
  else begin
    fail_cnt++;
    $error("core_wfi high after a reset cycle");
  end

endmodule

bind cpu_clk_pm cpu_aon_assertions u_cpu_aon_assertions (
  .clk         (clk),
  .rst_n       (rst_n),
  .state_q     (state_q),
  .irq_r       (irq_r),
  .irq_en      (irq_en),
  .wfi_req     (wfi_req),
  .clk_en      (clk_en),
  .core_cgstop (core_cgstop),
  .core_wfi    (core_wfi)
);

// File: dv/cpu_aon_tb.sv
//////////////////////////////////////////////////
// CPU always-on glue testbench
// Replays the pattern file against the top level
// and compares irq_r, clk_en and core_wfi
//////////////////////////////////////////////////

`timescale 1ns/1ps

module cpu_aon_tb;

  localparam PATTERN_FILE    = "dv/cpu_aon_patterns.txt";
  localparam CYCLES_PER_LINE = 50;
  localparam RESET_CYCLES    = 8;

  logic                   clk;
  logic                   rst_n;
  cpu_aon_pkg::irq_vec_t  irq_a;
  cpu_aon_pkg::irq_vec_t  irq_en;
  cpu_aon_pkg::unit_vec_t unit_active;
  logic                   core_cgstop;
  logic                   wfi_req;
  cpu_aon_pkg::irq_vec_t  irq_r;
  cpu_aon_pkg::unit_vec_t clk_en;
  logic                   core_wfi;

  // Fields of the current pattern line
  logic [8*24-1:0]        p_name;
  int                     p_op;
  cpu_aon_pkg::irq_vec_t  p_irq_a;
  cpu_aon_pkg::irq_vec_t  p_irq_en;
  cpu_aon_pkg::unit_vec_t p_active;
  logic                   p_cgstop;
  logic                   p_wfi;
  int                     p_cycles;
  cpu_aon_pkg::irq_vec_t  p_exp_irq;
  cpu_aon_pkg::unit_vec_t p_exp_clk;
  logic                   p_exp_wfi;

  int err_cnt     = 0;
  int other_cnt   = 0;
  int assert_cnt  = 0;
  int check_cnt   = 0;
  int n_lines     = 0;
  int cycle_cnt   = 0;
  int cycle_limit = 0;

  cpu_aon_top u_cpu_aon_top (
    .clk         (clk),
    .rst_n       (rst_n),
    .irq_a       (irq_a),
    .irq_en      (irq_en),
    .unit_active (unit_active),
    .core_cgstop (core_cgstop),
    .wfi_req     (wfi_req),
    .irq_r       (irq_r),
    .clk_en      (clk_en),
    .core_wfi    (core_wfi)
  );

  initial clk = 1'b0;
  always #10 clk = ~clk;

  // Run limit, armed once the pattern count is known
  always @(posedge clk) begin
    cycle_cnt++;
    if (cycle_limit > 0 && cycle_cnt > cycle_limit) begin
      $display("Run stopped after %0d cycles without reaching the end", cycle_limit);
      $display("TEST FAILED");
      $finish;
    end
  end

  //////////////////////////////////////////////////
  // Compare tasks
  //////////////////////////////////////////////////

  task automatic check_irq(input logic [8*24-1:0] name, input cpu_aon_pkg::irq_vec_t exp,
                           input cpu_aon_pkg::irq_vec_t act);
    check_cnt++;
    if (act !== exp) begin
      err_cnt++;
      $display("** Error: %0s irq_r expected %h actual %h", name, exp, act);
    end
  endtask

  task automatic check_units(input logic [8*24-1:0] name, input cpu_aon_pkg::unit_vec_t exp,
                             input cpu_aon_pkg::unit_vec_t act);
    check_cnt++;
    if (act !== exp) begin
      err_cnt++;
      $display("** Error: %0s clk_en expected %h actual %h", name, exp, act);
    end
  endtask

  task automatic check_bit(input logic [8*24-1:0] name, input logic exp, input logic act);
    check_cnt++;
    if (act !== exp) begin
      err_cnt++;
      $display("** Error: %0s core_wfi expected %b actual %b", name, exp, act);
    end
  endtask

  //////////////////////////////////////////////////
  // Pattern file handling
  //////////////////////////////////////////////////

  // Comment and blank lines give fewer than 11 fields
  task automatic parse_line(input logic [8*160-1:0] line_buf, output int fields);
    fields = $sscanf(line_buf, "%s %d %h %h %h %b %b %d %h %h %b", p_name, p_op,
                     p_irq_a, p_irq_en, p_active, p_cgstop, p_wfi, p_cycles,
                     p_exp_irq, p_exp_clk, p_exp_wfi);
  endtask

  task automatic count_pattern_lines(output int n);
    int               fd;
    int               fields;
    logic [8*160-1:0] line_buf;
    n = -1;
    fd = $fopen(PATTERN_FILE, "r");
    if (fd != 0) begin
      n = 0;
      while ($fgets(line_buf, fd) != 0) begin
        parse_line(line_buf, fields);
        if (fields == 11) n++;
      end
      $fclose(fd);
    end
  endtask

  // Entered and left 2 ns after a rising edge
  task automatic run_patterns();
    int               fd;
    int               fields;
    logic [8*160-1:0] line_buf;
    fd = $fopen(PATTERN_FILE, "r");
    if (fd == 0) begin
      other_cnt++;
      $display("Pattern file %0s could not be opened a second time", PATTERN_FILE);
    end else begin
      while ($fgets(line_buf, fd) != 0) begin
        parse_line(line_buf, fields);
        if (fields == 11) begin
          irq_a       = p_irq_a;
          irq_en      = p_irq_en;
          unit_active = p_active;
          core_cgstop = p_cgstop;
          wfi_req     = p_wfi;
          repeat (p_cycles) @(posedge clk);
          #1;
          if (p_op == 1) begin
            check_irq(p_name, p_exp_irq, irq_r);
            check_units(p_name, p_exp_clk, clk_en);
            check_bit(p_name, p_exp_wfi, core_wfi);
          end
          #1;
        end
      end
      $fclose(fd);
    end
  endtask

  initial begin
    rst_n       = 1'b0;
    irq_a       = '0;
    irq_en      = '0;
    unit_active = '0;
    core_cgstop = 1'b0;
    wfi_req     = 1'b0;
    count_pattern_lines(n_lines);
    if (n_lines <= 0) begin
      other_cnt++;
      $display("Pattern file %0s is missing or holds no pattern lines", PATTERN_FILE);
    end else begin
      cycle_limit = CYCLES_PER_LINE * n_lines + RESET_CYCLES;
      repeat (RESET_CYCLES) @(posedge clk);
      #2;
      rst_n = 1'b1;
      run_patterns();
    end
    assert_cnt = u_cpu_aon_top.u_cpu_clk_pm.u_cpu_aon_assertions.fail_cnt;
    $display("Checks %0d, value errors %0d, other errors %0d, assertion failures %0d",
             check_cnt, err_cnt, other_cnt, assert_cnt);
    if (err_cnt + other_cnt + assert_cnt == 0) begin
      $display("TEST OK");
    end else begin
      $display("TEST FAILED");
    end
    $finish;
  end

endmodule

// File: dv/cpu_aon_patterns.txt
# name op irq_a irq_en unit_active cgstop wfi_req cycles | exp irq_r clk_en core_wfi (hex/bin)
# op 1 checks the outputs after the cycles, op 0 only advances
reset_idle     1  0 0 0  0 0  1   0 0 0
irq_dbg_a      1  1 0 0  0 0  1   0 0 0
irq_dbg_b      1  1 0 0  0 0  1   1 0 0
irq_dbg_c      1  0 0 0  0 0  1   1 0 0
irq_dbg_d      1  0 0 0  0 0  1   0 0 0
irq_ext_set    1  2 0 0  0 0  2   2 0 0
irq_ext_clr    1  0 0 0  0 0  2   0 0 0
irq_sft_set    1  4 0 0  0 0  2   4 0 0
irq_sft_clr    1  0 0 0  0 0  2   0 0 0
irq_tmr_set    1  8 0 0  0 0  2   8 0 0
irq_tmr_clr    1  0 0 0  0 0  2   0 0 0
act_pulse      1  0 0 2  0 0  1   0 2 0
act_hold       1  0 0 0  0 0  3   0 2 0
act_drop       1  0 0 0  0 0  1   0 0 0
act_start      1  0 0 1  0 0  1   0 1 0
act_gap        1  0 0 0  0 0  2   0 1 0
act_restart    1  0 0 1  0 0  1   0 1 0
act_tail       1  0 0 0  0 0  3   0 1 0
act_end        1  0 0 0  0 0  1   0 0 0
sleep_req      1  0 1 f  0 1  1   0 0 1
sleep_masked   1  2 1 f  0 0  2   2 0 1
wake_sync      1  3 1 f  0 0  2   3 0 1
wake_state     1  3 1 f  0 0  1   3 f 0
wfi_refused    1  3 1 f  0 1  1   3 f 0
irq_drop       0  0 1 0  0 0  2   0 0 0
cg_run         1  0 1 0  1 0  1   0 f 0
cg_sleep       1  0 1 0  1 1  1   0 f 1
cg_off         1  0 1 0  0 0  1   0 0 1
cg_wake        1  1 1 0  0 0  3   1 0 0

// File: vlog.f
+incdir+rtl
rtl/cpu_aon_pkg.sv
rtl/cpu_irq_sync.sv
rtl/cpu_activity_mon.sv
rtl/cpu_clk_pm.sv
rtl/cpu_aon_top.sv
dv/cpu_aon_assertions.sv
dv/cpu_aon_tb.sv

// File: Bender.yml
package:
  name: cpu_aon

sources:
  # Design sources
  - include_dirs:
      - rtl
    files:
      - rtl/cpu_aon_pkg.sv
      - rtl/cpu_irq_sync.sv
      - rtl/cpu_activity_mon.sv
      - rtl/cpu_clk_pm.sv
      - rtl/cpu_aon_top.sv

  # Verification sources
  - target: test
    files:
      - dv/cpu_aon_assertions.sv
      - dv/cpu_aon_tb.sv
